//--- src/rd_dma_settings.svh
`ifndef RD_DMA_SETTINGS_SVH
`define RD_DMA_SETTINGS_SVH

// Scratchpad line size in bytes
`define RD_DMA_LINE_BYTES 16

// Byte address into a 4 KB scratchpad
`define RD_DMA_ADDR_WIDTH 12

// Transfer length in bytes
`define RD_DMA_LEN_WIDTH 10

// Accelerator channels sharing the read port
`define RD_DMA_ACCEL_COUNT 4

// Lines each channel can buffer, which sets its credit limit
`define RD_DMA_FIFO_LINES 2

`endif

//--- src/rd_dma_pkg.sv
`include "rd_dma_settings.svh"

package rd_dma_pkg;

  localparam int BYTE_PTR_W  = $clog2(`RD_DMA_LINE_BYTES);
  localparam int LINE_ADDR_W = `RD_DMA_ADDR_WIDTH - BYTE_PTR_W;
  localparam int LINE_CNT_W  = `RD_DMA_LEN_WIDTH - BYTE_PTR_W;
  localparam int ACCEL_ID_W  = $clog2(`RD_DMA_ACCEL_COUNT);
  localparam int LINE_W      = 8 * `RD_DMA_LINE_BYTES;

  typedef logic [`RD_DMA_ADDR_WIDTH-1:0] byte_addr_t;
  typedef logic [LINE_ADDR_W-1:0]        line_addr_t;

  // Even lines live in bank 0, odd lines in bank 1
  typedef logic [LINE_ADDR_W-2:0]        bank_addr_t;

  typedef logic [`RD_DMA_LEN_WIDTH-1:0]  byte_len_t;

  // Lengths above 1008 bytes do not fit
  typedef logic [LINE_CNT_W-1:0]         line_cnt_t;

  typedef logic [BYTE_PTR_W-1:0]         byte_ptr_t;
  typedef logic [ACCEL_ID_W-1:0]         accel_id_t;
  typedef logic [LINE_W-1:0]             line_t;

endpackage

//--- src/rr_arbiter.sv
`timescale 1ns/1ns

module rr_arbiter #(
  parameter int PORTS = 4
) (
  input  logic                                         clk,
  input  logic                                         rst,
  input  logic [PORTS-1:0]                             request,
  output logic [PORTS-1:0]                             grant,
  output logic                                         grant_valid,
  output logic [(PORTS > 1 ? $clog2(PORTS) : 1)-1:0]   grant_encoded
);

  localparam int ENC_W = (PORTS > 1) ? $clog2(PORTS) : 1;

  // Requester with the highest priority this cycle
  logic [ENC_W-1:0] prio;

  always_comb begin : pick
    int unsigned idx;
    grant         = '0;
    grant_encoded = '0;
    grant_valid   = 1'b0;
    for (int i = 0; i < PORTS; i++) begin
      idx = (int'(prio) + i) % PORTS;
      if (!grant_valid && request[idx]) begin
        grant_valid   = 1'b1;
        grant[idx]    = 1'b1;
        grant_encoded = ENC_W'(idx);
      end
    end
  end

  // Priority moves to just after the winner
  always_ff @(posedge clk) begin
    if (rst) begin
      prio <= '0;
    end else if (grant_valid) begin
      prio <= (int'(grant_encoded) == PORTS - 1) ? '0 : grant_encoded + 1'b1;
    end
  end

  a_grant_legal: assert property (@(posedge clk) disable iff (rst)
    $onehot0(grant) && ((grant & ~request) == '0));

endmodule

//--- src/scratchpad_banks.sv
`timescale 1ns/1ns

module scratchpad_banks
  import rd_dma_pkg::*;
(
  input  logic       clk,
  input  logic       rd_en,
  input  bank_addr_t rd_addr_b0,
  input  bank_addr_t rd_addr_b1,
  input  logic       load_en,
  input  line_addr_t load_line_addr,
  input  line_t      load_data,
  output line_t      rd_data_b0,
  output line_t      rd_data_b1
);

  localparam int BANK_LINES = 2 ** (LINE_ADDR_W - 1);

  bank_addr_t rd_addr [2];
  line_t      rd_data [2];
  bank_addr_t load_bank_addr;

  assign rd_addr[0] = rd_addr_b0;
  assign rd_addr[1] = rd_addr_b1;

  // Lowest line bit picks the bank
  assign load_bank_addr = load_line_addr[LINE_ADDR_W-1:1];

  for (genvar b = 0; b < 2; b++) begin : g_bank
    line_t mem [BANK_LINES];

    always_ff @(posedge clk) begin
      if (load_en && (load_line_addr[0] == 1'(b))) begin
        mem[load_bank_addr] <= load_data;
      end
      if (rd_en) begin
        rd_data[b] <= mem[rd_addr[b]];
      end
    end
  end

  assign rd_data_b0 = rd_data[0];
  assign rd_data_b1 = rd_data[1];

endmodule

//--- src/rd_dma_engine.sv
`timescale 1ns/1ns
`include "rd_dma_settings.svh"

module rd_dma_engine
  import rd_dma_pkg::*;
(
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           desc_valid,
  input  accel_id_t                      desc_accel_id,
  input  byte_addr_t                     desc_addr,
  input  byte_len_t                      desc_len,
  input  logic [`RD_DMA_ACCEL_COUNT-1:0] m_stop,
  input  logic [`RD_DMA_ACCEL_COUNT-1:0] line_done,
  output logic [`RD_DMA_ACCEL_COUNT-1:0] accel_busy,
  output logic                           rd_en,
  output bank_addr_t                     rd_addr_b0,
  output bank_addr_t                     rd_addr_b1,
  input  line_t                          rd_data_b0,
  input  line_t                          rd_data_b1,
  output logic                           line_valid,
  output accel_id_t                      line_dest,
  output line_t                          line_data,
  output logic                           line_last,
  output byte_ptr_t                      line_final_ptr,
  output logic [`RD_DMA_ACCEL_COUNT-1:0] flush
);

  localparam int N        = `RD_DMA_ACCEL_COUNT;
  localparam int CREDIT_W = $clog2(`RD_DMA_FIFO_LINES + 1);
  // Issue, bank data, registered data
  localparam int DEPTH    = 3;

  logic       desc_v1;
  accel_id_t  desc_id_r;
  byte_addr_t desc_addr_r;
  byte_len_t  desc_len_r;
  line_cnt_t  desc_lines;
  byte_ptr_t  desc_last_ptr;

  logic [N-1:0] stop_r;

  line_addr_t   req_line     [N];
  line_cnt_t    req_cnt      [N];
  byte_ptr_t    req_last_ptr [N];
  byte_ptr_t    req_offset   [N];
  logic [N-1:0] req_v, req_v_next;

  line_addr_t   act_line     [N];
  line_cnt_t    act_cnt      [N];
  byte_ptr_t    act_last_ptr [N];
  byte_ptr_t    act_offset   [N];
  logic [N-1:0] act_v, act_v_next;

  logic [N-1:0] req_request, req_grant, act_request, act_grant, issue_grant;
  logic [N-1:0] credit_ok;
  logic         req_gv, act_gv, issue, issue_last;
  accel_id_t    req_id, act_id, issue_id;
  line_addr_t   issue_line, issue_next_line;
  line_cnt_t    issue_cnt;
  byte_ptr_t    issue_last_ptr, issue_offset;

  logic [DEPTH-1:0] pipe_v, pipe_last, pipe_odd;
  accel_id_t        pipe_dest   [DEPTH];
  byte_ptr_t        pipe_ptr    [DEPTH];
  byte_ptr_t        pipe_offset [DEPTH];
  line_t            data_b0_r, data_b1_r;
  logic [2*LINE_W-1:0] line_pair;

  always_ff @(posedge clk) begin
    desc_id_r   <= desc_accel_id;
    desc_addr_r <= desc_addr;
    desc_len_r  <= desc_len;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      desc_v1 <= 1'b0;
    end else begin
      desc_v1 <= desc_valid;
    end
  end

  // Partial last line counts as a whole line
  assign desc_lines    = line_cnt_t'(desc_len_r >> BYTE_PTR_W)
                       + line_cnt_t'(byte_ptr_t'(desc_len_r) != '0);
  assign desc_last_ptr = byte_ptr_t'(desc_len_r) - 1'b1;

  // Stop stays until the channel gets a new descriptor
  always_ff @(posedge clk) begin
    if (rst) begin
      stop_r <= '0;
    end else begin
      stop_r <= stop_r | m_stop;
      if (desc_v1) begin
        stop_r[desc_id_r] <= 1'b0;
      end
    end
  end

  assign flush      = stop_r | m_stop;
  assign accel_busy = req_v | act_v;

  assign req_request = req_v & credit_ok & ~stop_r;
  assign act_request = act_v & credit_ok & ~stop_r & {N{!req_gv}};

  rr_arbiter #(.PORTS(N)) i_req_arbiter (
    .clk           (clk),
    .rst           (rst),
    .request       (req_request),
    .grant         (req_grant),
    .grant_valid   (req_gv),
    .grant_encoded (req_id)
  );

  rr_arbiter #(.PORTS(N)) i_act_arbiter (
    .clk           (clk),
    .rst           (rst),
    .request       (act_request),
    .grant         (act_grant),
    .grant_valid   (act_gv),
    .grant_encoded (act_id)
  );

  // New requests take the read port first
  assign issue          = req_gv | act_gv;
  assign issue_grant    = req_grant | act_grant;
  assign issue_id       = req_gv ? req_id : act_id;
  assign issue_line     = req_gv ? req_line[req_id] : act_line[act_id];
  assign issue_cnt      = req_gv ? req_cnt[req_id] : act_cnt[act_id];
  assign issue_last_ptr = req_gv ? req_last_ptr[req_id] : act_last_ptr[act_id];
  assign issue_offset   = req_gv ? req_offset[req_id] : act_offset[act_id];
  assign issue_last     = (issue_cnt == line_cnt_t'(1));
  assign issue_next_line = issue_line + 1'b1;

  always_ff @(posedge clk) begin
    if (desc_v1) begin
      req_line[desc_id_r]     <= line_addr_t'(desc_addr_r >> BYTE_PTR_W);
      req_cnt[desc_id_r]      <= desc_lines;
      req_last_ptr[desc_id_r] <= desc_last_ptr;
      req_offset[desc_id_r]   <= byte_ptr_t'(desc_addr_r);
    end
    if (issue) begin
      act_line[issue_id]     <= issue_next_line;
      act_cnt[issue_id]      <= issue_cnt - 1'b1;
      act_last_ptr[issue_id] <= issue_last_ptr;
      act_offset[issue_id]   <= issue_offset;
    end
  end

  always_comb begin
    req_v_next = req_v & ~req_grant;
    act_v_next = act_v;
    if (issue) begin
      act_v_next[issue_id] = !issue_last;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      req_v <= '0;
      act_v <= '0;
    end else begin
      req_v <= req_v_next & ~stop_r;
      act_v <= act_v_next & ~stop_r;
      if (desc_v1) begin
        req_v[desc_id_r] <= 1'b1;
      end
    end
  end

  // Line L and L+1 always land in different banks
  always_ff @(posedge clk) begin
    rd_addr_b0     <= issue_next_line[LINE_ADDR_W-1:1];
    rd_addr_b1     <= issue_line[LINE_ADDR_W-1:1];
    pipe_dest[0]   <= issue_id;
    pipe_last[0]   <= issue_last;
    pipe_odd[0]    <= issue_line[0];
    pipe_ptr[0]    <= issue_last ? issue_last_ptr : '1;
    pipe_offset[0] <= issue_offset;
    for (int s = 1; s < DEPTH; s++) begin
      pipe_dest[s]   <= pipe_dest[s-1];
      pipe_last[s]   <= pipe_last[s-1];
      pipe_odd[s]    <= pipe_odd[s-1];
      pipe_ptr[s]    <= pipe_ptr[s-1];
      pipe_offset[s] <= pipe_offset[s-1];
    end
    data_b0_r <= rd_data_b0;
    data_b1_r <= rd_data_b1;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pipe_v <= '0;
    end else begin
      pipe_v <= {pipe_v[DEPTH-2:0], issue};
    end
  end

  assign rd_en = pipe_v[0];

  // Lower line in the low half, then drop the leading bytes
  assign line_pair = pipe_odd[DEPTH-1] ? {data_b0_r, data_b1_r} : {data_b1_r, data_b0_r};
  assign line_data = line_t'(line_pair >> {pipe_offset[DEPTH-1], 3'b000});

  assign line_valid     = pipe_v[DEPTH-1];
  assign line_dest      = pipe_dest[DEPTH-1];
  assign line_last      = pipe_last[DEPTH-1];
  assign line_final_ptr = pipe_ptr[DEPTH-1];

  // Lines granted but not yet popped by the stream
  for (genvar i = 0; i < N; i++) begin : g_credit
    logic [CREDIT_W-1:0] used;

    assign credit_ok[i] = int'(used) < `RD_DMA_FIFO_LINES;

    always_ff @(posedge clk) begin
      if (rst || stop_r[i]) begin
        used <= '0;
      end else if (issue_grant[i] && !line_done[i]) begin
        used <= used + 1'b1;
      end else if (!issue_grant[i] && line_done[i]) begin
        used <= used - 1'b1;
      end
    end
  end

  a_grant_has_credit: assert property (@(posedge clk) disable iff (rst)
    (issue_grant & ~credit_ok) == '0);

endmodule

//--- src/accel_byte_stream.sv
`timescale 1ns/1ns
`include "rd_dma_settings.svh"

module accel_byte_stream
  import rd_dma_pkg::*;
#(
  parameter int FIFO_LINES = `RD_DMA_FIFO_LINES
) (
  input  logic       clk,
  input  logic       rst,
  input  accel_id_t  channel,
  input  logic       line_valid,
  input  accel_id_t  line_dest,
  input  line_t      line_data,
  input  logic       line_last,
  input  byte_ptr_t  line_final_ptr,
  input  logic       flush,
  input  logic       m_tready,
  output logic [7:0] m_tdata,
  output logic       m_tlast,
  output logic       m_tvalid,
  output logic       line_done
);

  localparam int IDX_W = $clog2(FIFO_LINES);

  line_t                 fifo_data [FIFO_LINES];
  byte_ptr_t             fifo_ptr  [FIFO_LINES];
  logic [FIFO_LINES-1:0] fifo_last;
  logic [IDX_W-1:0]      wr_idx, rd_idx;
  logic [IDX_W:0]        count;
  byte_ptr_t             byte_ptr;
  logic                  wr_en, out_ready, load, at_end;

  assign wr_en     = line_valid && (line_dest == channel) && !flush;
  assign out_ready = !m_tvalid || m_tready;
  assign load      = out_ready && (count != '0) && !flush;
  assign at_end    = (byte_ptr == fifo_ptr[rd_idx]);
  assign line_done = load && at_end;

  always_ff @(posedge clk) begin
    if (wr_en) begin
      fifo_data[wr_idx] <= line_data;
      fifo_ptr[wr_idx]  <= line_final_ptr;
      fifo_last[wr_idx] <= line_last;
    end
  end

  always_ff @(posedge clk) begin
    if (rst || flush) begin
      wr_idx   <= '0;
      rd_idx   <= '0;
      count    <= '0;
      byte_ptr <= '0;
    end else begin
      if (wr_en) begin
        wr_idx <= wr_idx + 1'b1;
      end
      if (line_done) begin
        rd_idx <= rd_idx + 1'b1;
      end
      if (wr_en && !line_done) begin
        count <= count + 1'b1;
      end else if (!wr_en && line_done) begin
        count <= count - 1'b1;
      end
      if (load) begin
        byte_ptr <= at_end ? '0 : byte_ptr + 1'b1;
      end
    end
  end

  // Held until the current byte is taken
  always_ff @(posedge clk) begin
    if (load) begin
      m_tdata <= fifo_data[rd_idx][{byte_ptr, 3'b000} +: 8];
      m_tlast <= fifo_last[rd_idx] && at_end;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      m_tvalid <= 1'b0;
    end else if (out_ready) begin
      m_tvalid <= load;
    end
  end

  // Engine credits keep one slot free for every line in flight
  a_no_overflow: assert property (@(posedge clk) disable iff (rst)
    wr_en |-> int'(count) < FIFO_LINES);

endmodule

//--- src/rd_dma_top.sv
`timescale 1ns/1ns
`include "rd_dma_settings.svh"

module rd_dma_top
  import rd_dma_pkg::*;
(
  input  logic                             clk,
  input  logic                             rst,
  input  logic                             desc_valid,
  input  accel_id_t                        desc_accel_id,
  input  byte_addr_t                       desc_addr,
  input  byte_len_t                        desc_len,
  output logic [`RD_DMA_ACCEL_COUNT-1:0]   accel_busy,
  input  logic                             load_en,
  input  line_addr_t                       load_line_addr,
  input  line_t                            load_data,
  output logic [8*`RD_DMA_ACCEL_COUNT-1:0] m_tdata,
  output logic [`RD_DMA_ACCEL_COUNT-1:0]   m_tlast,
  output logic [`RD_DMA_ACCEL_COUNT-1:0]   m_tvalid,
  input  logic [`RD_DMA_ACCEL_COUNT-1:0]   m_tready,
  input  logic [`RD_DMA_ACCEL_COUNT-1:0]   m_stop
);

  localparam int N = `RD_DMA_ACCEL_COUNT;

  logic         rd_en;
  bank_addr_t   rd_addr_b0, rd_addr_b1;
  line_t        rd_data_b0, rd_data_b1;
  logic         line_valid, line_last;
  accel_id_t    line_dest;
  line_t        line_data;
  byte_ptr_t    line_final_ptr;
  logic [N-1:0] flush, line_done;

  rd_dma_engine i_engine (
    .clk            (clk),
    .rst            (rst),
    .desc_valid     (desc_valid),
    .desc_accel_id  (desc_accel_id),
    .desc_addr      (desc_addr),
    .desc_len       (desc_len),
    .m_stop         (m_stop),
    .line_done      (line_done),
    .accel_busy     (accel_busy),
    .rd_en          (rd_en),
    .rd_addr_b0     (rd_addr_b0),
    .rd_addr_b1     (rd_addr_b1),
    .rd_data_b0     (rd_data_b0),
    .rd_data_b1     (rd_data_b1),
    .line_valid     (line_valid),
    .line_dest      (line_dest),
    .line_data      (line_data),
    .line_last      (line_last),
    .line_final_ptr (line_final_ptr),
    .flush          (flush)
  );

  scratchpad_banks i_banks (
    .clk            (clk),
    .rd_en          (rd_en),
    .rd_addr_b0     (rd_addr_b0),
    .rd_addr_b1     (rd_addr_b1),
    .load_en        (load_en),
    .load_line_addr (load_line_addr),
    .load_data      (load_data),
    .rd_data_b0     (rd_data_b0),
    .rd_data_b1     (rd_data_b1)
  );

  // Each stream keeps only the lines addressed to it
  for (genvar i = 0; i < N; i++) begin : g_stream
    accel_byte_stream #(.FIFO_LINES(`RD_DMA_FIFO_LINES)) i_stream (
      .clk            (clk),
      .rst            (rst),
      .channel        (accel_id_t'(i)),
      .line_valid     (line_valid),
      .line_dest      (line_dest),
      .line_data      (line_data),
      .line_last      (line_last),
      .line_final_ptr (line_final_ptr),
      .flush          (flush[i]),
      .m_tready       (m_tready[i]),
      .m_tdata        (m_tdata[8*i +: 8]),
      .m_tlast        (m_tlast[i]),
      .m_tvalid       (m_tvalid[i]),
      .line_done      (line_done[i])
    );
  end

endmodule

//--- test/tb_rd_dma_model.svh
`ifndef TB_RD_DMA_MODEL_SVH
`define TB_RD_DMA_MODEL_SVH

localparam int SCRATCH_BYTES = 1 << `RD_DMA_ADDR_WIDTH;

// Byte copy of everything loaded into the banks
logic [7:0] mirror [SCRATCH_BYTES];

logic [15:0] lfsr_state = 16'd44;

// 16-bit Fibonacci LFSR with taps 16 14 13 11
function automatic logic lfsr_bit();
  logic fb;
  fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
  lfsr_state = {lfsr_state[14:0], fb};
  return fb;
endfunction

function automatic logic [7:0] lfsr_byte();
  logic [7:0] b;
  for (int i = 0; i < 8; i++) begin
    b[i] = lfsr_bit();
  end
  return b;
endfunction

// Byte k of a transfer is the scratchpad byte k past the start address
function automatic logic [7:0] expected_byte(input int addr, input int k);
  return mirror[(addr + k) % SCRATCH_BYTES];
endfunction

`endif

//--- test/tb_rd_dma.sv
`timescale 1ns/1ns
`include "rd_dma_settings.svh"

module tb_rd_dma
  import rd_dma_pkg::*;
();

  localparam int N               = `RD_DMA_ACCEL_COUNT;
  localparam int LINE_BYTES      = `RD_DMA_LINE_BYTES;
  localparam int CLK_PERIOD      = 8;
  localparam int WATCHDOG_MARGIN = 3000;

  `include "tb_rd_dma_model.svh"

  localparam int LINES = SCRATCH_BYTES / LINE_BYTES;

  logic           clk, rst;
  logic           desc_valid;
  accel_id_t      desc_accel_id;
  byte_addr_t     desc_addr;
  byte_len_t      desc_len;
  logic [N-1:0]   accel_busy;
  logic           load_en;
  line_addr_t     load_line_addr;
  line_t          load_data;
  logic [8*N-1:0] m_tdata;
  logic [N-1:0]   m_tlast, m_tvalid, m_tready, m_stop;

  logic         random_ready;
  int           exp_addr [N];
  int           exp_len [N];
  int           beat_cnt [N];
  bit           stream_done [N];
  logic [N-1:0] held_valid;
  logic [7:0]   held_data [N];
  int           pass_cnt = 0;
  int           fail_cnt = 0;
  int           busy_errs = 0;

  rd_dma_top i_rd_dma_top (
    .clk            (clk),
    .rst            (rst),
    .desc_valid     (desc_valid),
    .desc_accel_id  (desc_accel_id),
    .desc_addr      (desc_addr),
    .desc_len       (desc_len),
    .accel_busy     (accel_busy),
    .load_en        (load_en),
    .load_line_addr (load_line_addr),
    .load_data      (load_data),
    .m_tdata        (m_tdata),
    .m_tlast        (m_tlast),
    .m_tvalid       (m_tvalid),
    .m_tready       (m_tready),
    .m_stop         (m_stop)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // Lengths that never land on a whole number of lines
  function automatic int unaligned_len(input int offset);
    int len;
    len = 20 + 9 * offset;
    if (len % LINE_BYTES == 0) begin
      len++;
    end
    return len;
  endfunction

  function automatic int multi_len(input int ch);
    return 100 + 37 * ch;
  endfunction

  function automatic int total_bytes();
    int sum;
    sum = 64 + 240 + 90;
    for (int o = 1; o < LINE_BYTES; o++) begin
      sum += unaligned_len(o);
    end
    for (int c = 0; c < N; c++) begin
      sum += multi_len(c);
    end
    return sum;
  endfunction

  function automatic bit check_value(input string name, input int ch,
                                     input logic [31:0] exp, input logic [31:0] act);
    bit ok;
    ok = (exp == act);
    assert (ok) pass_cnt++;
    else begin
      $display("[FAIL] %s channel %0d: expected 0x%0h, got 0x%0h", name, ch, exp, act);
      fail_cnt++;
    end
    return ok;
  endfunction

  function automatic void check_true(input bit cond, input string what);
    assert (cond) pass_cnt++;
    else begin
      $display("Error: %s", what);
      fail_cnt++;
    end
  endfunction

  task automatic report_test(input int num, input string name, input bit ok);
    $display("test %0d %s: %s", num, name, ok ? "passed" : "failed");
  endtask

  task automatic load_scratchpad();
    line_t      line;
    logic [7:0] b;
    for (int l = 0; l < LINES; l++) begin
      for (int i = 0; i < LINE_BYTES; i++) begin
        b = lfsr_byte();
        mirror[l * LINE_BYTES + i] = b;
        line[8*i +: 8] = b;
      end
      @(posedge clk);
      load_en        <= 1'b1;
      load_line_addr <= line_addr_t'(l);
      load_data      <= line;
    end
    @(posedge clk);
    load_en <= 1'b0;
  endtask

  task automatic send_desc(input int ch, input int addr, input int len);
    @(posedge clk);
    exp_addr[ch]    = addr;
    exp_len[ch]     = len;
    beat_cnt[ch]    = 0;
    stream_done[ch] = 1'b0;
    desc_valid    <= 1'b1;
    desc_accel_id <= accel_id_t'(ch);
    desc_addr     <= byte_addr_t'(addr);
    desc_len      <= byte_len_t'(len);
    @(posedge clk);
    desc_valid <= 1'b0;
    // Table entry and busy follow one edge after intake
    @(posedge clk);
    @(negedge clk);
    if (!check_value("accel_busy", ch, 32'd1, 32'(accel_busy[ch]))) begin
      busy_errs++;
    end
  endtask

  task automatic wait_stream(input int ch);
    while (!stream_done[ch]) begin
      @(posedge clk);
    end
  endtask

  always @(posedge clk) begin : drive_ready
    logic [N-1:0] bits;
    if (random_ready) begin
      for (int c = 0; c < N; c++) begin
        bits[c] = lfsr_bit();
      end
      m_tready <= bits;
    end else begin
      m_tready <= '1;
    end
  end

  // A beat seen at the falling edge transfers on the next rising edge
  always @(negedge clk) begin : check_streams
    logic [7:0] data;
    for (int c = 0; c < N; c++) begin
      data = m_tdata[8*c +: 8];
      if (!rst) begin
        if (held_valid[c]) begin
          check_true(m_tvalid[c],
                     $sformatf("m_tvalid dropped before its beat on channel %0d", c));
          void'(check_value("m_tdata held", c, 32'(held_data[c]), 32'(data)));
        end
        if (m_tvalid[c] && m_tready[c]) begin
          if (beat_cnt[c] >= exp_len[c]) begin
            check_true(1'b0, $sformatf("unexpected extra beat on channel %0d", c));
          end else begin
            void'(check_value("m_tdata", c, 32'(expected_byte(exp_addr[c], beat_cnt[c])),
                              32'(data)));
            void'(check_value("m_tlast", c, 32'(beat_cnt[c] == exp_len[c] - 1),
                              32'(m_tlast[c])));
            beat_cnt[c]++;
            if (beat_cnt[c] == exp_len[c]) begin
              if (!check_value("accel_busy", c, 32'd0, 32'(accel_busy[c]))) begin
                busy_errs++;
              end
              stream_done[c] = 1'b1;
            end
          end
        end
      end
      held_valid[c] = m_tvalid[c] && !m_tready[c] && !rst;
      held_data[c]  = data;
    end
  end

  initial begin : watchdog
    #(CLK_PERIOD * (8 * total_bytes() + WATCHDOG_MARGIN));
    $display("Timeout: the streams did not complete in the expected time");
    $display("TEST FAILED");
    $finish;
  end

  initial begin : stimulus
    int fails_before;
    int late_beats;
    rst            = 1'b1;
    desc_valid     = 1'b0;
    desc_accel_id  = '0;
    desc_addr      = '0;
    desc_len       = '0;
    load_en        = 1'b0;
    load_line_addr = '0;
    load_data      = '0;
    m_tready       = '0;
    m_stop         = '0;
    random_ready   = 1'b0;
    held_valid     = '0;
    for (int c = 0; c < N; c++) begin
      exp_addr[c]    = 0;
      exp_len[c]     = 0;
      beat_cnt[c]    = 0;
      stream_done[c] = 1'b1;
    end
    repeat (5) @(posedge clk);
    rst <= 1'b0;
    load_scratchpad();

    fails_before = fail_cnt;
    send_desc(0, 'h040, 64);
    wait_stream(0);
    report_test(1, "aligned 64 bytes on channel 0", fail_cnt == fails_before);

    fails_before = fail_cnt;
    for (int o = 1; o < LINE_BYTES; o++) begin
      send_desc(1, 'h100 + 65 * o, unaligned_len(o));
      wait_stream(1);
    end
    report_test(2, "unaligned transfers on channel 1", fail_cnt == fails_before);

    fails_before = fail_cnt;
    random_ready <= 1'b1;
    for (int c = 0; c < N; c++) begin
      send_desc(c, 13 + 'h380 * c, multi_len(c));
    end
    for (int c = 0; c < N; c++) begin
      wait_stream(c);
    end
    report_test(3, "concurrent streams with back-pressure", fail_cnt == fails_before);

    fails_before = fail_cnt;
    late_beats = 0;
    send_desc(2, 'hC07, 240);
    while (beat_cnt[2] < 40) begin
      @(posedge clk);
    end
    @(posedge clk);
    m_stop <= 4'b0100;
    @(negedge clk);
    late_beats += int'(m_tvalid[2] && m_tready[2]);
    @(posedge clk);
    m_stop <= '0;
    for (int i = 0; i < 20 || m_tvalid[2]; i++) begin
      @(negedge clk);
      late_beats += int'(m_tvalid[2] && m_tready[2]);
    end
    check_true(late_beats <= 1, "more than one beat on channel 2 after the stop pulse");
    void'(check_value("accel_busy", 2, 32'd0, 32'(accel_busy[2])));
    send_desc(2, 'h0E3, 90);
    wait_stream(2);
    report_test(5, "stop on channel 2 and restart", fail_cnt == fails_before);

    repeat (10) @(posedge clk);
    report_test(4, "busy flag timing", busy_errs == 0);
    $display("checks: %0d passed, %0d failed", pass_cnt, fail_cnt);
    if (fail_cnt == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

//--- all.f
+incdir+src
+incdir+test
src/rd_dma_pkg.sv
src/rr_arbiter.sv
src/scratchpad_banks.sv
src/rd_dma_engine.sv
src/accel_byte_stream.sv
src/rd_dma_top.sv
test/tb_rd_dma.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f all.f --top-module tb_rd_dma

out=$(./obj_dir/Vtb_rd_dma)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx 'TEST OK'; then
  exit 0
fi
exit 1
